//--- Bender.yml
package:
  name: serial_bus

sources:
  - files:
      - design/serial_bus_pkg.sv
      - design/slave_memory.sv
      - design/slave_port.sv
      - design/bus_arbiter.sv
      - design/master_port.sv
      - design/serial_bus_top.sv
  - target: simulation
    files:
      - sim/serial_bus_properties.sv
      - sim/serial_bus_tb.sv

//--- design/bus_arbiter.sv
// ###################################################################
// round-robin arbiter for two master ports
// routes the granted master's lines to the slave and back
// ###################################################################
`timescale 1ns/1ps

module bus_arbiter import serial_bus_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic m0_bus_req, m1_bus_req,
	output logic m0_bus_gnt, m1_bus_gnt,
	// master side lines
	input  logic m0_read_en, m0_write_en, m0_master_valid, m0_master_ready,
	input  logic m0_rx_address, m0_rx_data,
	input  logic m1_read_en, m1_write_en, m1_master_valid, m1_master_ready,
	input  logic m1_rx_address, m1_rx_data,
	// routed to the slave
	output logic read_en, write_en, master_valid, master_ready, rx_address, rx_data,
	// slave responses and per-master copies
	input  logic slave_ready, slave_valid, tx_data,
	output logic m0_slave_ready, m0_slave_valid, m0_tx_data,
	output logic m1_slave_ready, m1_slave_valid, m1_tx_data
);

	logic [N_MASTERS-1:0] req_vec;
	logic [N_MASTERS-1:0] gnt;
	// index of the master granted most recently
	logic                 last_win;

	assign req_vec = {m1_bus_req, m0_bus_req};
	assign m0_bus_gnt = gnt[0];
	assign m1_bus_gnt = gnt[1];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			gnt <= '0;
			// m0 takes the first tie
			last_win <= 1'b1;
		end
		else if (gnt == '0)
		begin
			// on a tie the other master than last time wins
			if (req_vec[0] && (!req_vec[1] || last_win))
			begin
				gnt <= N_MASTERS'(1);
				last_win <= 1'b0;
			end
			else if (req_vec[1])
			begin
				gnt <= N_MASTERS'(2);
				last_win <= 1'b1;
			end
		end
		// holder let go, a new grant waits a cycle
		else if ((gnt & req_vec) == '0)
			gnt <= '0;
	end

	// all zero with no grant
	assign read_en = (gnt[0] & m0_read_en) | (gnt[1] & m1_read_en);
	assign write_en = (gnt[0] & m0_write_en) | (gnt[1] & m1_write_en);
	assign master_valid = (gnt[0] & m0_master_valid) | (gnt[1] & m1_master_valid);
	assign master_ready = (gnt[0] & m0_master_ready) | (gnt[1] & m1_master_ready);
	assign rx_address = (gnt[0] & m0_rx_address) | (gnt[1] & m1_rx_address);
	assign rx_data = (gnt[0] & m0_rx_data) | (gnt[1] & m1_rx_data);

	// losing master sees a busy, silent slave
	assign m0_slave_ready = gnt[0] & slave_ready;
	assign m0_slave_valid = gnt[0] & slave_valid;
	assign m0_tx_data = gnt[0] & tx_data;
	assign m1_slave_ready = gnt[1] & slave_ready;
	assign m1_slave_valid = gnt[1] & slave_valid;
	assign m1_tx_data = gnt[1] & tx_data;

endmodule

//--- design/master_port.sv
// ###################################################################
// master port of the serial register bus
// client req/ack in, bus request, serial address/data out, read data in
// ###################################################################
`timescale 1ns/1ps

module master_port import serial_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	// client handshake
	input  logic              req,
	input  logic              we,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	output logic              ack,
	output logic [DATA_W-1:0] rdata,
	// arbiter handshake
	output logic              bus_req,
	input  logic              bus_gnt,
	// serial bus lines
	output logic              read_en,
	output logic              write_en,
	output logic              master_valid,
	output logic              master_ready,
	output logic              rx_address,
	output logic              rx_data,
	input  logic              slave_ready,
	input  logic              slave_valid,
	input  logic              tx_data
);

	typedef enum logic [2:0] {
		M_IDLE,
		M_BUS_REQ,
		M_SEND,
		M_WAIT,
		M_CLOSE
	} state_t;

	state_t                state;
	logic                  is_write;
	logic                  start;
	logic                  data_phase;
	logic [ADDR_CNT_W-1:0] bit_cnt;
	logic [ADDR_CNT_W-1:0] last_bit;
	logic [ADDR_W-1:0]     addr_sr;
	logic [DATA_W-1:0]     data_sr;
	logic [DATA_W-1:0]     rdata_sr;

	// new request only once the old grant is gone
	assign start = (state == M_IDLE) && req && !bus_gnt;

	// reads stop after the address, writes carry the data too
	assign last_bit = is_write ? ADDR_CNT_W'(ADDR_W + DATA_W - 1) : ADDR_CNT_W'(ADDR_W - 1);
	assign data_phase = (bit_cnt >= ADDR_CNT_W'(ADDR_W));

	// enables held from first bit to end of response
	assign read_en = ~is_write && (state == M_SEND || state == M_WAIT);
	assign write_en = is_write && (state == M_SEND || state == M_WAIT);
	assign master_valid = (state == M_SEND);
	// ready only while expecting read data
	assign master_ready = (state == M_WAIT) && ~is_write;

	// lsb first, lines quiet outside their phase
	assign rx_address = master_valid & ~data_phase & addr_sr[0];
	assign rx_data = master_valid & data_phase & data_sr[0];
	assign rdata = rdata_sr;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= M_IDLE;
			is_write <= 1'b0;
			bit_cnt <= '0;
			bus_req <= 1'b0;
			ack <= 1'b0;
		end
		else
		begin
			case (state)
				M_IDLE:
				begin
					if (start)
					begin
						is_write <= we;
						bus_req <= 1'b1;
						state <= M_BUS_REQ;
					end
				end
				// wait for grant and an idle slave
				M_BUS_REQ:
				begin
					if (bus_gnt && slave_ready)
					begin
						bit_cnt <= '0;
						state <= M_SEND;
					end
				end
				M_SEND:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == last_bit)
						state <= M_WAIT;
				end
				// slave back to idle ends the transfer
				M_WAIT:
				begin
					if (slave_ready)
					begin
						ack <= 1'b1;
						state <= M_CLOSE;
					end
				end
				// client drops req, then ack and bus_req fall
				M_CLOSE:
				begin
					if (!req)
					begin
						ack <= 1'b0;
						bus_req <= 1'b0;
						state <= M_IDLE;
					end
				end
				default:
					state <= M_IDLE;
			endcase
		end
	end

	// address and data shifters, read data assembly
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			addr_sr <= addr;
			data_sr <= wdata;
		end
		else if (master_valid && !data_phase)
			addr_sr <= addr_sr >> 1;
		else if (master_valid)
			data_sr <= data_sr >> 1;
		// read bits arrive lsb first
		if (slave_valid && master_ready)
			rdata_sr <= {tx_data, rdata_sr[DATA_W-1:1]};
	end

endmodule

//--- design/serial_bus_pkg.sv
// ###################################################################
// serial register bus constants
// widths, memory size, master count and counter width
// ###################################################################
package serial_bus_pkg;

	// address bits sent first, then data bits
	localparam int ADDR_W = 12;
	localparam int DATA_W = 8;

	// one byte per address
	localparam int MEM_DEPTH = 4096;

	// clients sharing the bus
	localparam int N_MASTERS = 2;

	// holds a bit index up to ADDR_W + DATA_W
	localparam int ADDR_CNT_W = 5;

endpackage

//--- design/serial_bus_top.sv
// ###################################################################
// serial register bus top
// two master ports, arbiter, slave port and byte memory
// ###################################################################
`timescale 1ns/1ps

module serial_bus_top import serial_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              m0_req, m0_we,
	input  logic [ADDR_W-1:0] m0_addr,
	input  logic [DATA_W-1:0] m0_wdata,
	output logic              m0_ack,
	output logic [DATA_W-1:0] m0_rdata,
	input  logic              m1_req, m1_we,
	input  logic [ADDR_W-1:0] m1_addr,
	input  logic [DATA_W-1:0] m1_wdata,
	output logic              m1_ack,
	output logic [DATA_W-1:0] m1_rdata
);

	// master side of the arbiter
	logic m0_bus_req, m0_bus_gnt, m0_read_en, m0_write_en, m0_master_valid;
	logic m0_master_ready, m0_rx_address, m0_rx_data;
	logic m0_slave_ready, m0_slave_valid, m0_tx_data;
	logic m1_bus_req, m1_bus_gnt, m1_read_en, m1_write_en, m1_master_valid;
	logic m1_master_ready, m1_rx_address, m1_rx_data;
	logic m1_slave_ready, m1_slave_valid, m1_tx_data;
	// shared bus and memory side
	logic read_en, write_en, master_valid, master_ready, rx_address, rx_data;
	logic slave_ready, slave_valid, tx_data, mem_re, mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata, mem_rdata;

	master_port i_master0 (
		.clk, .rst_n,
		.req(m0_req), .we(m0_we), .addr(m0_addr), .wdata(m0_wdata),
		.ack(m0_ack), .rdata(m0_rdata), .bus_req(m0_bus_req), .bus_gnt(m0_bus_gnt),
		.read_en(m0_read_en), .write_en(m0_write_en), .master_valid(m0_master_valid),
		.master_ready(m0_master_ready), .rx_address(m0_rx_address), .rx_data(m0_rx_data),
		.slave_ready(m0_slave_ready), .slave_valid(m0_slave_valid), .tx_data(m0_tx_data)
	);

	master_port i_master1 (
		.clk, .rst_n,
		.req(m1_req), .we(m1_we), .addr(m1_addr), .wdata(m1_wdata),
		.ack(m1_ack), .rdata(m1_rdata), .bus_req(m1_bus_req), .bus_gnt(m1_bus_gnt),
		.read_en(m1_read_en), .write_en(m1_write_en), .master_valid(m1_master_valid),
		.master_ready(m1_master_ready), .rx_address(m1_rx_address), .rx_data(m1_rx_data),
		.slave_ready(m1_slave_ready), .slave_valid(m1_slave_valid), .tx_data(m1_tx_data)
	);

	bus_arbiter i_arbiter (
		.clk, .rst_n, .m0_bus_req, .m1_bus_req, .m0_bus_gnt, .m1_bus_gnt,
		.m0_read_en, .m0_write_en, .m0_master_valid, .m0_master_ready,
		.m0_rx_address, .m0_rx_data,
		.m1_read_en, .m1_write_en, .m1_master_valid, .m1_master_ready,
		.m1_rx_address, .m1_rx_data,
		.read_en, .write_en, .master_valid, .master_ready, .rx_address, .rx_data,
		.slave_ready, .slave_valid, .tx_data,
		.m0_slave_ready, .m0_slave_valid, .m0_tx_data,
		.m1_slave_ready, .m1_slave_valid, .m1_tx_data
	);

	slave_port i_slave (
		.clk, .rst_n, .read_en, .write_en, .master_valid, .master_ready,
		.rx_address, .rx_data, .slave_ready, .slave_valid, .tx_data,
		.mem_addr, .mem_wdata, .mem_re, .mem_we, .mem_rdata
	);

	slave_memory i_memory (
		.clk, .mem_addr, .mem_wdata, .mem_re, .mem_we, .mem_rdata
	);

endmodule

//--- design/slave_memory.sv
// ###################################################################
// byte memory behind the slave port
// synchronous write, registered read
// ###################################################################
`timescale 1ns/1ps

module slave_memory import serial_bus_pkg::*;
(
	input  logic              clk,
	input  logic [ADDR_W-1:0] mem_addr,
	input  logic [DATA_W-1:0] mem_wdata,
	input  logic              mem_re,
	input  logic              mem_we,
	output logic [DATA_W-1:0] mem_rdata
);

	logic [DATA_W-1:0] mem [MEM_DEPTH];

	always_ff @(posedge clk)
	begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		// data out one cycle after the read strobe
		if (mem_re)
			mem_rdata <= mem[mem_addr];
	end

endmodule

//--- design/slave_port.sv
// ###################################################################
// slave port of the serial register bus
// deserialises address/data, strobes the memory, returns read data
// ###################################################################
`timescale 1ns/1ps

module slave_port import serial_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              read_en,
	input  logic              write_en,
	input  logic              master_valid,
	input  logic              master_ready,
	input  logic              rx_address,
	input  logic              rx_data,
	output logic              slave_ready,
	output logic              slave_valid,
	output logic              tx_data,
	// memory side
	output logic [ADDR_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	output logic              mem_re,
	output logic              mem_we,
	input  logic [DATA_W-1:0] mem_rdata
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RX,
		S_STROBE,
		S_LOAD,
		S_TX
	} state_t;

	state_t                state;
	logic                  is_write;
	logic                  rx_start;
	logic                  rx_done;
	logic [ADDR_CNT_W-1:0] rx_cnt;
	logic [ADDR_CNT_W-1:0] rx_last;
	logic [ADDR_CNT_W-1:0] tx_cnt;
	logic [ADDR_W-1:0]     addr_sr;
	logic [DATA_W-1:0]     data_sr;
	logic [DATA_W-1:0]     tx_sr;

	// first address bit seen while idle
	assign rx_start = (state == S_IDLE) && master_valid && (read_en || write_en);
	assign rx_last = is_write ? ADDR_CNT_W'(ADDR_W + DATA_W - 1) : ADDR_CNT_W'(ADDR_W - 1);

	// one cycle after the last received bit
	assign rx_done = (state == S_STROBE);
	assign mem_we = rx_done & is_write;
	assign mem_re = rx_done & ~is_write;
	assign mem_addr = addr_sr;
	assign mem_wdata = data_sr;

	assign slave_ready = (state == S_IDLE);
	assign slave_valid = (state == S_TX);
	assign tx_data = slave_valid & tx_sr[0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			is_write <= 1'b0;
			rx_cnt <= '0;
			tx_cnt <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					// bit 0 taken here
					if (rx_start)
					begin
						is_write <= write_en;
						rx_cnt <= ADDR_CNT_W'(1);
						state <= S_RX;
					end
				end
				// gaps in master_valid just stall the count
				S_RX:
				begin
					if (master_valid)
					begin
						rx_cnt <= rx_cnt + 1'b1;
						if (rx_cnt == rx_last)
							state <= S_STROBE;
					end
				end
				S_STROBE:
					state <= is_write ? S_IDLE : S_LOAD;
				// memory data valid this cycle
				S_LOAD:
				begin
					tx_cnt <= '0;
					state <= S_TX;
				end
				// advance only when the master takes the bit
				S_TX:
				begin
					if (master_ready)
					begin
						tx_cnt <= tx_cnt + 1'b1;
						if (tx_cnt == ADDR_CNT_W'(DATA_W - 1))
							state <= S_IDLE;
					end
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// receive and transmit shifters, lsb first
	always_ff @(posedge clk)
	begin
		if (rx_start)
			addr_sr <= {rx_address, addr_sr[ADDR_W-1:1]};
		else if (state == S_RX && master_valid && rx_cnt < ADDR_CNT_W'(ADDR_W))
			addr_sr <= {rx_address, addr_sr[ADDR_W-1:1]};
		else if (state == S_RX && master_valid)
			data_sr <= {rx_data, data_sr[DATA_W-1:1]};
		if (state == S_LOAD)
			tx_sr <= mem_rdata;
		else if (slave_valid && master_ready)
			tx_sr <= tx_sr >> 1;
	end

endmodule

//--- serial_bus_top.f
design/serial_bus_pkg.sv
design/slave_memory.sv
design/slave_port.sv
design/bus_arbiter.sv
design/master_port.sv
design/serial_bus_top.sv
sim/serial_bus_properties.sv
sim/serial_bus_tb.sv

//--- sim/serial_bus_properties.sv
// ####################################################################
// bus protocol properties for the arbiter and the slave port
// ####################################################################
`timescale 1ns/1ps

module serial_bus_properties
	import serial_bus_pkg::*;
(
	input logic                 clk,
	input logic                 rst_n,
	input logic [N_MASTERS-1:0] gnt,
	input logic [N_MASTERS-1:0] req,
	input logic                 read_en,
	input logic                 slave_valid,
	input logic                 slave_ready,
	input logic                 strobe
);

	// strobes since the slave went busy
	logic [1:0] strobe_cnt;
	// assertion failures so far
	int         fail_count = 0;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			strobe_cnt <= '0;
		else if (slave_ready)
			strobe_cnt <= '0;
		else if (strobe && strobe_cnt != 2'd3)
			strobe_cnt <= strobe_cnt + 1'b1;
	end

	one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(gnt[0] && gnt[1]))
		else
		begin
			$error("both masters granted at once");
			fail_count++;
		end
	gnt0_on_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(gnt[0]) |-> req[0])
		else
		begin
			$error("m0 granted without a request");
			fail_count++;
		end
	gnt1_on_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(gnt[1]) |-> req[1])
		else
		begin
			$error("m1 granted without a request");
			fail_count++;
		end
	valid_in_read: assert property (@(posedge clk) disable iff (!rst_n) slave_valid |-> read_en)
		else
		begin
			$error("slave_valid outside a read");
			fail_count++;
		end
	// only the first strobe of a transfer
	single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		strobe |-> strobe_cnt == 2'd0)
		else
		begin
			$error("extra memory strobe in one transfer");
			fail_count++;
		end
	strobe_seen: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(slave_ready) |-> strobe_cnt == 2'd1)
		else
		begin
			$error("transfer ended without a memory strobe");
			fail_count++;
		end

endmodule

// no strobes at the arbiter so slave_ready tied high keeps those checks idle
bind bus_arbiter serial_bus_properties i_arbiter_props (
	.clk, .rst_n, .gnt(gnt), .req(req_vec), .read_en, .slave_valid,
	.slave_ready(1'b1), .strobe(1'b0)
);

// slave port sees no grants
bind slave_port serial_bus_properties i_slave_props (
	.clk, .rst_n, .gnt('0), .req('0), .read_en, .slave_valid, .slave_ready,
	.strobe(mem_re | mem_we)
);

//--- sim/serial_bus_tb.sv
// ####################################################################
// testbench for the serial register bus
// client transfers on both masters checked against a reference memory
// ####################################################################
`timescale 1ns/1ps

module serial_bus_tb
	import serial_bus_pkg::*;
();

	// lfsr writes in the last test
	localparam int N_RAND = 16;
	// transfers over all tests
	localparam int N_TRANSFERS = 2 + 2 + 4 + 2 * N_RAND;
	localparam int TIMEOUT_CYCLES = 2 * N_TRANSFERS * (ADDR_W + 2 * DATA_W + 20);

	logic              clk;
	logic              rst_n;
	logic              m0_req, m0_we, m0_ack;
	logic              m1_req, m1_we, m1_ack;
	logic [ADDR_W-1:0] m0_addr, m1_addr;
	logic [DATA_W-1:0] m0_wdata, m1_wdata, m0_rdata, m1_rdata;

	// expected memory contents
	logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
	logic [31:0]       lfsr;
	// pre-edge values from the previous clock
	logic [1:0]        prev_ack;
	logic [1:0]        prev_req;
	int                cycles;
	int                error_count;
	// master whose transfer finished most recently
	int                last_served;
	time               ack_time [N_MASTERS];

	serial_bus_top i_dut (
		.clk, .rst_n,
		.m0_req, .m0_we, .m0_addr, .m0_wdata, .m0_ack, .m0_rdata,
		.m1_req, .m1_we, .m1_addr, .m1_wdata, .m1_ack, .m1_rdata
	);

	// 100 ns period
	always #50 clk = ~clk;

	task automatic report_failure(input string msg);
		error_count++;
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// failures flagged by the bound protocol checkers
	function automatic int protocol_failures();
		return i_dut.i_arbiter.i_arbiter_props.fail_count
			+ i_dut.i_slave.i_slave_props.fail_count;
	endfunction

	// ack may only rise at an edge where req was high
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			assert (!m0_ack || prev_ack[0] || prev_req[0])
				else report_failure($sformatf("Mismatch at %0t: m0_ack rose without req", $time));
			assert (!m1_ack || prev_ack[1] || prev_req[1])
				else report_failure($sformatf("Mismatch at %0t: m1_ack rose without req", $time));
		end
		assert (protocol_failures() == 0)
			else report_failure("a bus protocol assertion failed");
		prev_ack <= {m1_ack, m0_ack};
		prev_req <= {m1_req, m0_req};
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			report_failure($sformatf("timeout after %0d cycles, a transfer never finished", cycles));
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic drive_client(input int master, input logic req, input logic we,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
		if (master == 0)
		begin
			m0_req = req;
			m0_we = we;
			m0_addr = addr;
			m0_wdata = wdata;
		end
		else
		begin
			m1_req = req;
			m1_we = we;
			m1_addr = addr;
			m1_wdata = wdata;
		end
	endtask

	function automatic logic ack_of(input int master);
		return (master == 0) ? m0_ack : m1_ack;
	endfunction

	function automatic logic [DATA_W-1:0] rdata_of(input int master);
		return (master == 0) ? m0_rdata : m1_rdata;
	endfunction

	// full four-phase client handshake driven on the falling edge
	task automatic run_transfer(input int master, input logic we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		@(negedge clk);
		drive_client(master, 1'b1, we, addr, wdata);
		@(negedge clk);
		while (!ack_of(master))
			@(negedge clk);
		// rdata holds while ack is high
		rdata = rdata_of(master);
		ack_time[master] = $time;
		drive_client(master, 1'b0, we, addr, wdata);
		@(negedge clk);
		while (ack_of(master))
			@(negedge clk);
		last_served = master;
	endtask

	task automatic write_byte(input int master, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] rdata_ignored;
		run_transfer(master, 1'b1, addr, data, rdata_ignored);
		ref_mem[addr] = data;
	endtask

	task automatic read_byte(input int master, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] expected);
		logic [DATA_W-1:0] got;
		run_transfer(master, 1'b0, addr, '0, got);
		assert (got === expected)
			else report_failure($sformatf(
				"Mismatch at %0t: m%0d read 0x%03h gave 0x%02h, expected 0x%02h",
				$time, master, addr, got, expected));
	endtask

	// quiet bus and no acks after reset
	task automatic check_idle_after_reset();
		repeat (8)
		begin
			@(negedge clk);
			assert (!m0_ack && !m1_ack)
				else report_failure($sformatf("Mismatch at %0t: ack high while idle", $time));
		end
	endtask

	task automatic write_then_read();
		write_byte(0, 12'h123, 8'h5a);
		read_byte(0, 12'h123, ref_mem[12'h123]);
	endtask

	// both masters reach the same memory
	task automatic cross_master_readback();
		write_byte(1, 12'hfed, 8'ha7);
		read_byte(0, 12'hfed, ref_mem[12'hfed]);
	endtask

	// tie goes to the master not served last
	task automatic simultaneous_requests();
		int first;
		first = 1 - last_served;
		fork
			write_byte(0, 12'h3c0, 8'h96);
			write_byte(1, 12'h0a5, 8'h3e);
		join
		assert (ack_time[first] < ack_time[1 - first])
			else report_failure($sformatf("Mismatch at %0t: m%0d was acked before m%0d on a tie",
				$time, 1 - first, first));
		read_byte(1, 12'h3c0, ref_mem[12'h3c0]);
		read_byte(0, 12'h0a5, ref_mem[12'h0a5]);
	endtask

	task automatic random_fill();
		logic [ADDR_W-1:0] addrs [N_RAND];
		logic [31:0]       r;
		logic [DATA_W-1:0] d;
		for (int i = 0; i < N_RAND; i++)
		begin
			random_bits(ADDR_W, r);
			addrs[i] = r[ADDR_W-1:0];
			random_bits(DATA_W, r);
			d = r[DATA_W-1:0];
			// last write hits an earlier address with new data
			if (i == N_RAND - 1)
			begin
				addrs[i] = addrs[3];
				d = ~ref_mem[addrs[i]];
			end
			write_byte(i % 2, addrs[i], d);
		end
		// read back through the other master
		for (int i = 0; i < N_RAND; i++)
			read_byte((i + 1) % 2, addrs[i], ref_mem[addrs[i]]);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		drive_client(0, 1'b0, 1'b0, '0, '0);
		drive_client(1, 1'b0, 1'b0, '0, '0);
		lfsr = 32'h9622_cc75;
		prev_ack = '0;
		prev_req = '0;
		cycles = 0;
		error_count = 0;
		last_served = 0;
		// reset over 4 clocks
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		check_idle_after_reset();
		write_then_read();
		cross_master_readback();
		simultaneous_requests();
		random_fill();
		@(negedge clk);
		if (error_count == 0 && protocol_failures() == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
